// File: Makefile
# Verilator build and run for the byte memory port

TOP := byte_mem_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert --timescale 1ns/100ps \
		-f byte_mem.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
		echo "$$out"; \
		echo "$$out" | grep -q "TEST RESULT: PASS"

clean:
	rm -rf obj_dir

// File: access_decode.sv
// ----------------------------------------
// Request stage that checks alignment and
// builds byte enables and store lanes
// ----------------------------------------
`timescale 1ns/100ps

module access_decode (
   input  logic                                clk,
   input  logic                                reset,
   input  logic                                req_valid,
   input  logic                                req_write,
   input  logic [1:0]                          req_size,
   input  logic                                req_unsigned,
   input  logic [mem_port_pkg::BYTE_ADDR_W-1:0] req_addr,
   input  logic [mem_port_pkg::DATA_W-1:0]      req_wdata,
   ram_port_if.requester                       ram,
   output logic                                ld_valid,
   output logic                                ld_err,
   output logic [1:0]                          ld_size,
   output logic                                ld_unsigned,
   output logic [1:0]                          ld_offset
);
   import mem_port_pkg::*;

   logic [1:0]           offset;
   logic                 aligned;
   logic [NUM_BYTES-1:0] be_mask;
   mem_word_u            store_word;

   assign offset = req_addr[1:0];   // Byte lane within the word

   // Alignment, lane mask and store data replication
   always_comb begin
      aligned    = 1'b0;
      be_mask    = '0;
      store_word = '0;
      case (req_size)
         SIZE_BYTE: begin
            aligned = 1'b1;
            be_mask = NUM_BYTES'(1) << offset;
            for (int i = 0; i < NUM_BYTES; i++) begin
               store_word.lanes[i] = req_wdata[BYTE_W-1:0];
            end
         end
         SIZE_HALF: begin
            aligned = ~offset[0];   // Even address only
            be_mask = offset[1] ? 4'b1100 : 4'b0011;
            for (int i = 0; i < NUM_HALVES; i++) begin
               store_word.halves[i] = req_wdata[2*BYTE_W-1:0];
            end
         end
         SIZE_WORD: begin
            aligned          = (offset == 2'd0);
            be_mask          = '1;
            store_word.lanes = req_wdata;
         end
         default: begin
            aligned = 1'b0;   // Code 3 counts as misaligned
         end
      endcase
   end

   // Control state cleared by reset
   always_ff @(posedge clk) begin
      if (reset) begin
         ram.en   <= 1'b0;
         ld_valid <= 1'b0;
         ld_err   <= 1'b0;
      end else begin
         ram.en   <= req_valid & aligned;
         ld_valid <= req_valid & aligned & ~req_write;   // Stores give no response
         ld_err   <= req_valid & ~aligned;
      end
   end

   // Command payload and load control on the same edge
   always_ff @(posedge clk) begin
      ram.we      <= req_write ? be_mask : '0;   // Loads read with no lane enabled
      ram.addr    <= req_addr[BYTE_ADDR_W-1:2];
      ram.wdata   <= store_word;
      ld_size     <= req_size;
      ld_unsigned <= req_unsigned;
      ld_offset   <= offset;
   end

endmodule

// File: byte_mem.f
mem_port_pkg.sv
ram_port_if.sv
sp_ram_be.sv
access_decode.sv
load_align.sv
byte_mem_top.sv
byte_mem_tb.sv

// File: byte_mem_tb.sv
// ----------------------------------------
// Directed testbench for the data memory
// port with a byte-array reference model
// ----------------------------------------
`timescale 1ns/100ps

module byte_mem_tb;
   import mem_port_pkg::*;

   localparam int CLK_PERIOD      = 40;
   localparam int RESET_CYCLES    = 16;
   localparam int DIRECTED_CYCLES = 120;   // Upper bound for tests 1 to 5
   localparam int FILL_WORDS      = 64;
   localparam int RAND_OPS        = 200;
   localparam int MARGIN_CYCLES   = 100;
   localparam int WATCHDOG_CYCLES = RESET_CYCLES + DIRECTED_CYCLES + FILL_WORDS
                                    + RAND_OPS + 6 * 3 + MARGIN_CYCLES;
   localparam logic [BYTE_ADDR_W-1:0] RAND_BASE = 12'h400;

   logic                   clk;
   logic                   reset;
   logic                   req_valid;
   logic                   req_write;
   logic [1:0]             req_size;
   logic                   req_unsigned;
   logic [BYTE_ADDR_W-1:0] req_addr;
   logic [DATA_W-1:0]      req_wdata;
   logic                   rsp_valid;
   logic                   rsp_err;
   logic [DATA_W-1:0]      rsp_data;

   logic [7:0]        ref_mem [0:(1<<BYTE_ADDR_W)-1];   // Byte-addressed model
   logic              exp_valid [3];   // Index 2 is due at this falling edge
   logic              exp_err   [3];
   logic [DATA_W-1:0] exp_data  [3];
   int                check_count;
   int                error_count;
   int                test_errors;
   integer            seed;

   byte_mem_top u_byte_mem_top (
      .clk          (clk),
      .reset        (reset),
      .req_valid    (req_valid),
      .req_write    (req_write),
      .req_size     (req_size),
      .req_unsigned (req_unsigned),
      .req_addr     (req_addr),
      .req_wdata    (req_wdata),
      .rsp_valid    (rsp_valid),
      .rsp_err      (rsp_err),
      .rsp_data     (rsp_data)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   function automatic logic is_aligned(input logic [1:0] size,
                                       input logic [BYTE_ADDR_W-1:0] addr);
      case (size)
         SIZE_BYTE: return 1'b1;
         SIZE_HALF: return ~addr[0];
         SIZE_WORD: return (addr[1:0] == 2'd0);
         default:   return 1'b0;
      endcase
   endfunction

   // Little endian so lane 0 holds the lowest byte address
   function automatic logic [DATA_W-1:0] model_load(input logic [1:0] size, input logic uns,
                                                    input logic [BYTE_ADDR_W-1:0] addr);
      logic [7:0]  b;
      logic [15:0] h;
      b = ref_mem[addr];
      h = {ref_mem[addr + 12'd1], ref_mem[addr]};
      case (size)
         SIZE_BYTE: return uns ? {24'h0, b} : {{24{b[7]}}, b};
         SIZE_HALF: return uns ? {16'h0, h} : {{16{h[15]}}, h};
         default:   return {ref_mem[addr + 12'd3], ref_mem[addr + 12'd2], h};
      endcase
   endfunction

   task automatic model_store(input logic [1:0] size, input logic [BYTE_ADDR_W-1:0] addr,
                              input logic [DATA_W-1:0] wdata);
      case (size)
         SIZE_BYTE: ref_mem[addr] = wdata[7:0];
         SIZE_HALF: begin
            ref_mem[addr]         = wdata[7:0];
            ref_mem[addr + 12'd1] = wdata[15:8];
         end
         default: begin
            for (int i = 0; i < 4; i++) ref_mem[addr + 12'(i)] = wdata[8*i +: 8];
         end
      endcase
   endtask

   task automatic push_expect(input logic v, input logic e, input logic [DATA_W-1:0] d);
      for (int i = 2; i > 0; i--) begin
         exp_valid[i] = exp_valid[i-1];
         exp_err[i]   = exp_err[i-1];
         exp_data[i]  = exp_data[i-1];
      end
      exp_valid[0] = v;
      exp_err[0]   = e;
      exp_data[0]  = d;
   endtask

   // Outputs against the request issued three falling edges earlier
   task automatic check_response();
      check_count++;
      assert (rsp_valid === exp_valid[2] && rsp_err === exp_err[2]
              && rsp_data === exp_data[2])
      else begin
         error_count++;
         test_errors++;
         $display("[FAIL] %0d ns: got valid %b err %b data %h, expected %b %b %h", $time,
                  rsp_valid, rsp_err, rsp_data, exp_valid[2], exp_err[2], exp_data[2]);
      end
   endtask

   task automatic issue(input logic wr, input logic [1:0] size, input logic uns,
                        input logic [BYTE_ADDR_W-1:0] addr, input logic [DATA_W-1:0] wdata);
      logic ok;
      @(negedge clk);
      check_response();
      req_valid    = 1'b1;
      req_write    = wr;
      req_size     = size;
      req_unsigned = uns;
      req_addr     = addr;
      req_wdata    = wdata;
      ok = is_aligned(size, addr);
      if (ok && !wr) push_expect(1'b1, 1'b0, model_load(size, uns, addr));
      else           push_expect(1'b0, ~ok, '0);   // Stores give no response
      if (ok && wr) model_store(size, addr, wdata);
   endtask

   task automatic idle();
      @(negedge clk);
      check_response();
      req_valid = 1'b0;
      push_expect(1'b0, 1'b0, '0);
   endtask

   task automatic finish_test(input string name);
      string verdict;
      repeat (3) idle();   // Last response is due
      if (test_errors == 0) begin
         verdict = "ok";
      end else begin
         verdict = "failed";
      end
      $display("%s %s, %0d errors", name, verdict, test_errors);
      test_errors = 0;
   endtask

   function automatic logic [DATA_W-1:0] fill_word(input logic [ADDR_W-1:0] waddr);
      return {waddr, ~waddr, waddr ^ 10'h2B5, 2'b01};
   endfunction

   task automatic word_store_load();
      repeat (4) idle();   // Outputs quiet after reset
      issue(1'b1, SIZE_WORD, 1'b0, 12'h010, 32'hDEAD_BEEF);
      idle();
      issue(1'b0, SIZE_WORD, 1'b0, 12'h010, '0);
      issue(1'b1, SIZE_WORD, 1'b0, 12'hFFC, 32'h0123_4567);
      issue(1'b0, SIZE_WORD, 1'b0, 12'hFFC, '0);
      finish_test("word_store_load");
   endtask

   task automatic partial_stores();
      issue(1'b1, SIZE_WORD, 1'b0, 12'h040, 32'h1122_3344);
      issue(1'b1, SIZE_BYTE, 1'b0, 12'h041, 32'hFFFF_FFAB);
      issue(1'b0, SIZE_WORD, 1'b0, 12'h040, '0);
      issue(1'b1, SIZE_HALF, 1'b0, 12'h042, 32'h1234_BEEF);
      issue(1'b0, SIZE_WORD, 1'b0, 12'h040, '0);
      issue(1'b1, SIZE_BYTE, 1'b0, 12'h043, 32'h0000_005A);
      issue(1'b1, SIZE_HALF, 1'b0, 12'h040, 32'h0000_9966);
      issue(1'b0, SIZE_WORD, 1'b0, 12'h040, '0);
      finish_test("partial_stores");
   endtask

   // Every byte and halfword of the first pattern has its top bit set
   task automatic sign_extension();
      logic [BYTE_ADDR_W-1:0] base;
      for (int p = 0; p < 2; p++) begin
         base = 12'h0C0 + 12'(4 * p);
         issue(1'b1, SIZE_WORD, 1'b0, base, (p == 0) ? 32'hF08C_A59B : 32'h7F3C_1205);
         for (int u = 0; u < 2; u++) begin
            for (int off = 0; off < 4; off++) issue(1'b0, SIZE_BYTE, 1'(u), base + 12'(off), '0);
            issue(1'b0, SIZE_HALF, 1'(u), base, '0);
            issue(1'b0, SIZE_HALF, 1'(u), base + 12'd2, '0);
         end
      end
      finish_test("sign_extension");
   endtask

   task automatic back_to_back();
      issue(1'b1, SIZE_WORD, 1'b0, 12'h100, 32'h0BAD_F00D);
      issue(1'b0, SIZE_WORD, 1'b0, 12'h100, '0);   // Sees the store just before
      issue(1'b1, SIZE_BYTE, 1'b0, 12'h101, 32'h0000_00C3);
      issue(1'b0, SIZE_BYTE, 1'b0, 12'h101, '0);
      issue(1'b0, SIZE_HALF, 1'b1, 12'h102, '0);
      issue(1'b1, SIZE_HALF, 1'b0, 12'h104, 32'h0000_8421);
      issue(1'b1, SIZE_HALF, 1'b0, 12'h106, 32'h0000_1248);
      issue(1'b0, SIZE_WORD, 1'b0, 12'h104, '0);
      issue(1'b0, SIZE_BYTE, 1'b1, 12'h100, '0);
      issue(1'b0, SIZE_HALF, 1'b0, 12'h106, '0);
      finish_test("back_to_back");
   endtask

   task automatic misaligned();
      issue(1'b1, SIZE_WORD, 1'b0, 12'h080, 32'hCAFE_1234);
      issue(1'b1, SIZE_HALF, 1'b0, 12'h081, 32'h0000_FFFF);
      issue(1'b1, SIZE_HALF, 1'b0, 12'h083, 32'h0000_EEEE);
      idle();
      issue(1'b1, SIZE_WORD, 1'b0, 12'h082, 32'h5555_5555);
      issue(1'b0, SIZE_WORD, 1'b0, 12'h081, '0);
      issue(1'b0, SIZE_HALF, 1'b0, 12'h081, '0);
      issue(1'b1, 2'd3, 1'b0, 12'h080, 32'h7777_7777);   // Illegal size code
      issue(1'b0, 2'd3, 1'b0, 12'h080, '0);
      issue(1'b0, SIZE_WORD, 1'b0, 12'h080, '0);
      finish_test("misaligned");
   endtask

   task automatic random_access();
      logic [31:0]            r;
      logic [29:0]            sel;
      logic [BYTE_ADDR_W-1:0] addr;
      logic [1:0]             size;
      for (int w = 0; w < FILL_WORDS; w++) begin
         addr = RAND_BASE + 12'(4 * w);
         issue(1'b1, SIZE_WORD, 1'b0, addr, fill_word(addr[BYTE_ADDR_W-1:2]));
      end
      for (int n = 0; n < RAND_OPS; n++) begin
         r    = $random(seed);
         sel  = r[31:2] % 30'd3;
         size = sel[1:0];
         addr = RAND_BASE | {4'd0, r[15:8]};
         if (size == SIZE_HALF) addr[0] = 1'b0;
         if (size == SIZE_WORD) addr[1:0] = 2'd0;
         issue(r[0], size, r[1], addr, $random(seed));
      end
      finish_test("random_access");
   endtask

   initial begin
      reset        = 1'b1;
      req_valid    = 1'b0;
      req_write    = 1'b0;
      req_size     = SIZE_BYTE;
      req_unsigned = 1'b0;
      req_addr     = '0;
      req_wdata    = '0;
      check_count  = 0;
      error_count  = 0;
      test_errors  = 0;
      seed         = 32'h7866;
      for (int i = 0; i < 3; i++) begin
         exp_valid[i] = 1'b0;
         exp_err[i]   = 1'b0;
         exp_data[i]  = '0;
      end
      repeat (RESET_CYCLES) @(negedge clk);
      reset = 1'b0;

      word_store_load();
      partial_stores();
      sign_extension();
      back_to_back();
      misaligned();
      random_access();

      $display("Checks: %0d passed, %0d failed", check_count - error_count, error_count);
      if (error_count == 0) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

   // Watchdog sized from the cycle count of all tests
   initial begin
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      $display("Timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
      $display("TEST RESULT: FAIL");
      $finish;
   end

endmodule

// File: byte_mem_top.sv
// ----------------------------------------
// Byte-addressable data memory port
// ----------------------------------------
`timescale 1ns/100ps

module byte_mem_top (
   input  logic                                 clk,
   input  logic                                 reset,
   input  logic                                 req_valid,
   input  logic                                 req_write,
   input  logic [1:0]                           req_size,
   input  logic                                 req_unsigned,
   input  logic [mem_port_pkg::BYTE_ADDR_W-1:0] req_addr,
   input  logic [mem_port_pkg::DATA_W-1:0]      req_wdata,
   output logic                                 rsp_valid,
   output logic                                 rsp_err,
   output logic [mem_port_pkg::DATA_W-1:0]      rsp_data
);

   // Load control from request to response stage
   logic       ld_valid;
   logic       ld_err;
   logic [1:0] ld_size;
   logic       ld_unsigned;
   logic [1:0] ld_offset;

   ram_port_if u_ram_if ();

   access_decode u_access_decode (
      .clk          (clk),
      .reset        (reset),
      .req_valid    (req_valid),
      .req_write    (req_write),
      .req_size     (req_size),
      .req_unsigned (req_unsigned),
      .req_addr     (req_addr),
      .req_wdata    (req_wdata),
      .ram          (u_ram_if.requester),
      .ld_valid     (ld_valid),
      .ld_err       (ld_err),
      .ld_size      (ld_size),
      .ld_unsigned  (ld_unsigned),
      .ld_offset    (ld_offset)
   );

   sp_ram_be u_sp_ram_be (
      .clk (clk),
      .ram (u_ram_if.memory)
   );

   load_align u_load_align (
      .clk         (clk),
      .reset       (reset),
      .ram         (u_ram_if.reader),
      .ld_valid    (ld_valid),
      .ld_err      (ld_err),
      .ld_size     (ld_size),
      .ld_unsigned (ld_unsigned),
      .ld_offset   (ld_offset),
      .rsp_valid   (rsp_valid),
      .rsp_err     (rsp_err),
      .rsp_data    (rsp_data)
   );

endmodule

// File: load_align.sv
// ----------------------------------------
// Response stage that extracts and extends
// load data and raises the error pulse
// ----------------------------------------
`timescale 1ns/100ps

module load_align (
   input  logic                           clk,
   input  logic                           reset,
   ram_port_if.reader                     ram,
   input  logic                           ld_valid,
   input  logic                           ld_err,
   input  logic [1:0]                     ld_size,
   input  logic                           ld_unsigned,
   input  logic [1:0]                     ld_offset,
   output logic                           rsp_valid,
   output logic                           rsp_err,
   output logic [mem_port_pkg::DATA_W-1:0] rsp_data
);
   import mem_port_pkg::*;

   // Load control lined up with the RAM read word
   logic       s_valid;
   logic       s_err;
   logic [1:0] s_size;
   logic       s_unsigned;
   logic [1:0] s_offset;

   mem_word_u           rd_word;
   logic [BYTE_W-1:0]   sel_byte;
   logic [2*BYTE_W-1:0] sel_half;
   logic [DATA_W-1:0]   load_word;

   always_ff @(posedge clk) begin
      if (reset) begin
         s_valid <= 1'b0;
         s_err   <= 1'b0;
      end else begin
         s_valid <= ld_valid;
         s_err   <= ld_err;
      end
   end

   always_ff @(posedge clk) begin
      s_size     <= ld_size;
      s_unsigned <= ld_unsigned;
      s_offset   <= ld_offset;
   end

   assign rd_word  = ram.rdata;
   assign sel_byte = rd_word.lanes[s_offset];
   assign sel_half = rd_word.halves[s_offset[1]];   // Upper or lower halfword

   // Zero or sign extension by size
   always_comb begin
      case (s_size)
         SIZE_BYTE: load_word = s_unsigned ? {{(DATA_W-BYTE_W){1'b0}}, sel_byte}
                                           : {{(DATA_W-BYTE_W){sel_byte[BYTE_W-1]}}, sel_byte};
         SIZE_HALF: load_word = s_unsigned ? {{(DATA_W-2*BYTE_W){1'b0}}, sel_half}
                                           : {{(DATA_W-2*BYTE_W){sel_half[2*BYTE_W-1]}}, sel_half};
         default:   load_word = rd_word;
      endcase
   end

   // Registered response with data zero when idle
   always_ff @(posedge clk) begin
      if (reset) begin
         rsp_valid <= 1'b0;
         rsp_err   <= 1'b0;
         rsp_data  <= '0;
      end else begin
         rsp_valid <= s_valid;
         rsp_err   <= s_err;
         rsp_data  <= s_valid ? load_word : '0;
      end
   end

endmodule

// File: mem_port_pkg.sv
// ----------------------------------------
// Data memory port package
// Widths, size codes and the word view
// ----------------------------------------
package mem_port_pkg;

   // Word and lane geometry
   localparam int DATA_W    = 32;
   localparam int BYTE_W    = 8;
   localparam int NUM_BYTES = DATA_W / BYTE_W;
   localparam int NUM_HALVES = NUM_BYTES / 2;

   // 1024 words of RAM
   localparam int ADDR_W      = 10;
   localparam int BYTE_ADDR_W = ADDR_W + 2;   // Adds the lane offset

   // Access size codes where 3 is illegal
   localparam logic [1:0] SIZE_BYTE = 2'd0;
   localparam logic [1:0] SIZE_HALF = 2'd1;
   localparam logic [1:0] SIZE_WORD = 2'd2;

   // One memory word seen as byte lanes or as halfwords
   typedef union packed {
      logic [NUM_BYTES-1:0][BYTE_W-1:0]    lanes;
      logic [NUM_HALVES-1:0][2*BYTE_W-1:0] halves;
   } mem_word_u;

endpackage

// File: ram_port_if.sv
// ----------------------------------------
// RAM command and read data bundle
// ----------------------------------------
`timescale 1ns/100ps

interface ram_port_if;
   import mem_port_pkg::*;

   logic                 en;
   logic [NUM_BYTES-1:0] we;      // One write enable per byte lane
   logic [ADDR_W-1:0]    addr;    // Word address
   logic [DATA_W-1:0]    wdata;
   logic [DATA_W-1:0]    rdata;   // Word as it was before the write

   // Request stage drives the command
   modport requester (
      output en,
      output we,
      output addr,
      output wdata
   );

   modport memory (
      input  en,
      input  we,
      input  addr,
      input  wdata,
      output rdata
   );

   // Response stage only sees the read word
   modport reader (
      input rdata
   );

endinterface

// File: sp_ram_be.sv
// ----------------------------------------
// Single-port RAM with byte write enables
// Read-first with one word per clock
// ----------------------------------------
`timescale 1ns/100ps

module sp_ram_be (
   input logic        clk,
   ram_port_if.memory ram
);
   import mem_port_pkg::*;

   // Contents undefined until written
   logic [DATA_W-1:0] mem_array [2**ADDR_W];

   // Byte columns are written independently
   always_ff @(posedge clk) begin
      if (ram.en) begin
         for (int i = 0; i < NUM_BYTES; i++) begin
            if (ram.we[i]) begin
               mem_array[ram.addr][i*BYTE_W +: BYTE_W] <= ram.wdata[i*BYTE_W +: BYTE_W];
            end
         end
      end
   end

   // Read-first so rdata returns the word as it was before this write
   always_ff @(posedge clk) begin
      if (ram.en) begin
         ram.rdata <= mem_array[ram.addr];
      end
      // Holds the last word while idle
   end

endmodule
